// ==== design/block_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "prefetch_consts.svh"

module block_fetch import wb_bus_pkg::*, prefetch_pkg::*; (
   input  logic     clk_i,
   input  logic     rst_i,
   // Block handshake with the controller.
   input  logic     blk_req_i,
   input  blk_num_t blk_num_i,
   output logic     blk_ack_o,
   output logic     blk_err_o,
   // Port A master, read only.
   output logic     a_cyc_o,
   output logic     a_stb_o,
   output logic     a_we_o,
   output wb_adr_t  a_adr_o,
   input  wb_dat_t  a_dat_i,
   input  logic     a_ack_i,
   input  logic     a_wat_i,
   input  logic     a_err_i,
   // Word path into block_store.
   output logic     wr_valid_o,
   output wb_dat_t  wr_data_o,
   input  logic     buf_space_i
);

   localparam blk_off_t BSIZE_OFF = blk_off_t'(`PF_BSIZE);
   localparam blk_off_t LAST_OFF  = blk_off_t'(`PF_BSIZE - 1);

   logic     stb_q;
   blk_off_t iss_cnt;
   blk_off_t ack_cnt;
   logic     word_done;
   logic     issue;
   wb_adr_t  blk_base;

   // --------------------------------------------------
   // Bus outputs and word hand-off.
   // --------------------------------------------------

   // Strobe is withheld during slave wait states.
   assign a_stb_o = stb_q && !a_wat_i;
   assign a_we_o  = 1'b0;

   // An erroring cycle never delivers a word.
   assign word_done  = a_stb_o && a_ack_i && !a_err_i;
   assign wr_valid_o = word_done;
   assign wr_data_o  = a_dat_i;

   // Stride is a power of two, so the index fills the low bits.
   assign blk_base = wb_adr_t'(blk_num_i) * wb_adr_t'(`PF_BSTRIDE);
   assign a_adr_o  = blk_base | wb_adr_t'(ack_cnt);

   // Next word goes out when the strobe is free or just completing.
   // buf_space_i already counts the word handed over this cycle.
   assign issue = (iss_cnt < BSIZE_OFF) && buf_space_i && (!stb_q || word_done);

   // --------------------------------------------------
   // Block cycle control.
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         a_cyc_o   <= 1'b0;
         stb_q     <= 1'b0;
         iss_cnt   <= '0;
         ack_cnt   <= '0;
         blk_ack_o <= 1'b0;
         blk_err_o <= 1'b0;
      end else if (!a_cyc_o) begin
         if (blk_ack_o) begin
            // Wait for the controller to drop its request.
            if (!blk_req_i) begin
               blk_ack_o <= 1'b0;
            end
         end else if (blk_req_i) begin
            // Bus cycle opens one cycle after the request.
            a_cyc_o   <= 1'b1;
            blk_err_o <= 1'b0;
            ack_cnt   <= '0;
            stb_q     <= buf_space_i;
            iss_cnt   <= buf_space_i ? blk_off_t'(1) : '0;
         end
      end else if (a_err_i) begin
         // Abort the block, no further reads.
         a_cyc_o   <= 1'b0;
         stb_q     <= 1'b0;
         blk_ack_o <= 1'b1;
         blk_err_o <= 1'b1;
      end else if (word_done && (ack_cnt == LAST_OFF)) begin
         // Last word of the block.
         a_cyc_o   <= 1'b0;
         stb_q     <= 1'b0;
         blk_ack_o <= 1'b1;
      end else begin
         if (word_done) begin
            ack_cnt <= ack_cnt + blk_off_t'(1);
         end
         if (issue) begin
            stb_q   <= 1'b1;
            iss_cnt <= iss_cnt + blk_off_t'(1);
         end else if (word_done) begin
            stb_q <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/block_store.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "prefetch_consts.svh"

module block_store import wb_bus_pkg::*; #(
   parameter int BUF_DEPTH = `PF_BSIZE
) (
   input  logic    clk_i,
   input  logic    rst_i,
   // High for the whole prefetch.
   input  logic    run_i,
   // Words from block_fetch.
   input  logic    wr_valid_i,
   input  wb_dat_t wr_data_i,
   output logic    buf_space_o,
   output logic    buf_empty_o,
   // Port B master, write only.
   output logic    b_cyc_o,
   output logic    b_stb_o,
   output logic    b_we_o,
   output wb_adr_t b_adr_o,
   output wb_dat_t b_dat_o,
   input  logic    b_ack_i,
   input  logic    b_wat_i
);

   // Pointer and occupancy widths, valid down to one entry.
   localparam int PW = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
   localparam int OW = $clog2(BUF_DEPTH + 1);
   localparam logic [PW-1:0] LAST_PTR = PW'(BUF_DEPTH - 1);
   localparam logic [OW:0]   DEPTH_W  = (OW + 1)'(BUF_DEPTH);

   wb_dat_t       mem [BUF_DEPTH];
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [OW-1:0] occ;
   logic [OW:0]   occ_in;
   logic          run_q;
   logic          b_done;
   logic          pop;

   // --------------------------------------------------
   // Buffer status.
   // --------------------------------------------------

   // Occupancy including the word arriving this cycle.
   assign occ_in      = {1'b0, occ} + {{OW{1'b0}}, wr_valid_i};
   assign buf_space_o = occ_in < DEPTH_W;
   // Empty only once the last word has left port B too.
   assign buf_empty_o = (occ == '0) && !b_stb_o;

   // An acknowledge counts only outside wait states.
   assign b_done = b_stb_o && b_ack_i && !b_wat_i;
   // Head word moves to port B when the bus is free or freeing up.
   assign pop = (occ != '0) && (!b_stb_o || b_done);

   assign b_cyc_o = b_stb_o;
   assign b_we_o  = b_cyc_o;

   // --------------------------------------------------
   // FIFO control and port B.
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         occ     <= '0;
         run_q   <= 1'b0;
         b_stb_o <= 1'b0;
         b_adr_o <= '0;
      end else begin
         run_q <= run_i;
         if (wr_valid_i) begin
            wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + PW'(1);
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + PW'(1);
         end
         case ({wr_valid_i, pop})
            2'b10:   occ <= occ + OW'(1);
            2'b01:   occ <= occ - OW'(1);
            default: occ <= occ;
         endcase
         // Strobe stays up across back-to-back words.
         if (pop) begin
            b_stb_o <= 1'b1;
         end else if (b_done) begin
            b_stb_o <= 1'b0;
         end
         // Sink address restarts at zero with every prefetch.
         if (run_i && !run_q) begin
            b_adr_o <= '0;
         end else if (b_done) begin
            b_adr_o <= b_adr_o + wb_adr_t'(1);
         end
      end
   end

   // Word storage and the port B data register.
   // Data holds until the sink acknowledges.
   always_ff @(posedge clk_i) begin
      if (wr_valid_i) begin
         mem[wr_ptr] <= wr_data_i;
      end
      if (pop) begin
         b_dat_o <= mem[rd_ptr];
      end
   end

endmodule

`default_nettype wire

// ==== design/prefetch_consts.svh ====
`ifndef PREFETCH_CONSTS_SVH
`define PREFETCH_CONSTS_SVH

// --------------------------------------------------
// Prefetcher sizing, shared by RTL and testbench.
// --------------------------------------------------

// Data word width on both master ports.
`define PF_WIDTH 32

// Address bits, the same on port A and port B.
`define PF_SBITS 10

// Bits of the in-block word index.
`define PF_BBITS 5

// Words read per block, less than the block stride.
`define PF_BSIZE 24

// Address distance between two block bases.
`define PF_BSTRIDE (1 << `PF_BBITS)

`endif

// ==== design/prefetch_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "prefetch_consts.svh"

module prefetch_ctrl import prefetch_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_i,
   // Four-phase start handshake from the requester.
   input  logic      start_req_i,
   input  pf_count_t count_i,
   output logic      start_ack_o,
   output logic      err_o,
   // Four-phase block handshake with block_fetch.
   output logic      blk_req_o,
   output blk_num_t  blk_num_o,
   input  logic      blk_ack_i,
   input  logic      blk_err_i,
   // Buffer status from block_store.
   input  logic      buf_empty_i,
   output logic      run_o
);

   ctrl_state_t state;
   pf_count_t   count_q;
   pf_count_t   total;
   pf_count_t   total_add;
   logic        last_blk;
   logic        err_seen;
   logic        empty_q;

   // Words moved once the current block is done.
   assign total_add = total + pf_count_t'(`PF_BSIZE);

   // --------------------------------------------------
   // Sequencer FSM.
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state       <= IDLE;
         count_q     <= '0;
         total       <= '0;
         last_blk    <= 1'b0;
         err_seen    <= 1'b0;
         empty_q     <= 1'b0;
         blk_req_o   <= 1'b0;
         blk_num_o   <= '0;
         run_o       <= 1'b0;
         start_ack_o <= 1'b0;
         err_o       <= 1'b0;
      end else begin
         // Buffer must read empty two cycles in a row.
         empty_q <= buf_empty_i;
         case (state)
            IDLE: begin
               // Request seen here is always a fresh one.
               // Count is sampled once, on this cycle.
               if (start_req_i) begin
                  count_q   <= count_i;
                  total     <= '0;
                  last_blk  <= 1'b0;
                  err_seen  <= 1'b0;
                  blk_num_o <= '0;
                  blk_req_o <= 1'b1;
                  run_o     <= 1'b1;
                  state     <= FETCH;
               end
            end
            FETCH: begin
               if (blk_req_o && blk_ack_i) begin
                  // Block finished, decide now whether it was the last.
                  blk_req_o <= 1'b0;
                  total     <= total_add;
                  err_seen  <= blk_err_i;
                  last_blk  <= blk_err_i || (total_add >= count_q) || (blk_num_o == '1);
               end else if (!blk_req_o && !blk_ack_i) begin
                  // Handshake back at rest.
                  if (last_blk) begin
                     state <= WAIT_DRAIN;
                  end else begin
                     blk_num_o <= blk_num_o + blk_num_t'(1);
                     blk_req_o <= 1'b1;
                  end
               end
            end
            WAIT_DRAIN: begin
               // All words are in the buffer now, wait for port B.
               if (buf_empty_i && empty_q) begin
                  run_o <= 1'b0;
                  state <= DONE;
               end
            end
            DONE: begin
               start_ack_o <= 1'b1;
               err_o       <= err_seen;
               state       <= ACK;
            end
            ACK: begin
               // Acknowledge falls one cycle after the request drops.
               if (!start_req_i) begin
                  start_ack_o <= 1'b0;
                  err_o       <= 1'b0;
                  state       <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== design/prefetch_pkg.sv ====
`default_nettype none

`include "prefetch_consts.svh"

// --------------------------------------------------
// Control-side types for the prefetch sequencer.
// --------------------------------------------------
package prefetch_pkg;

   // Requested word count, one bit wider than an address.
   // A full address space of words fits.
   typedef logic [`PF_SBITS:0] pf_count_t;

   // Block number, the upper part of a port A address.
   typedef logic [`PF_SBITS-`PF_BBITS-1:0] blk_num_t;

   // Controller states.
   // FETCH covers the block handshakes, WAIT_DRAIN lets
   // port B empty the buffer, ACK holds the start handshake.
   typedef enum logic [2:0] {
      IDLE,
      FETCH,
      WAIT_DRAIN,
      DONE,
      ACK
   } ctrl_state_t;

endpackage

`default_nettype wire

// ==== design/wb_bus_pkg.sv ====
`default_nettype none

`include "prefetch_consts.svh"

// --------------------------------------------------
// Bus-side types for the two master ports.
// --------------------------------------------------
package wb_bus_pkg;

   // Word address on port A or port B.
   // Port A splits it into block number and index.
   typedef logic [`PF_SBITS-1:0] wb_adr_t;

   // One data word as read from the source.
   // Port B writes the same word to the sink.
   typedef logic [`PF_WIDTH-1:0] wb_dat_t;

   // Word index inside a block.
   // Wide enough for the full stride, so it also
   // holds a count of PF_BSIZE.
   typedef logic [`PF_BBITS-1:0] blk_off_t;

endpackage

`default_nettype wire

// ==== design/wb_prefetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_prefetch_top import wb_bus_pkg::*, prefetch_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_i,
   // Start handshake.
   input  logic      start_req_i,
   input  pf_count_t count_i,
   output logic      start_ack_o,
   output logic      err_o,
   // Port A, towards the source slave.
   output logic      a_cyc_o,
   output logic      a_stb_o,
   output logic      a_we_o,
   output wb_adr_t   a_adr_o,
   input  wb_dat_t   a_dat_i,
   input  logic      a_ack_i,
   input  logic      a_wat_i,
   input  logic      a_err_i,
   // Port B, towards the sink slave.
   output logic      b_cyc_o,
   output logic      b_stb_o,
   output logic      b_we_o,
   output wb_adr_t   b_adr_o,
   output wb_dat_t   b_dat_o,
   input  logic      b_ack_i,
   input  logic      b_wat_i
);

   // --------------------------------------------------
   // Stage interconnect.
   // --------------------------------------------------
   logic     blk_req;
   blk_num_t blk_num;
   logic     blk_ack;
   logic     blk_err;
   logic     buf_empty;
   logic     run;
   logic     wr_valid;
   wb_dat_t  wr_data;
   logic     buf_space;

   // Start decode and block sequencing.
   prefetch_ctrl u_ctrl (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .start_req_i (start_req_i),
      .count_i     (count_i),
      .start_ack_o (start_ack_o),
      .err_o       (err_o),
      .blk_req_o   (blk_req),
      .blk_num_o   (blk_num),
      .blk_ack_i   (blk_ack),
      .blk_err_i   (blk_err),
      .buf_empty_i (buf_empty),
      .run_o       (run)
   );

   // Port A block reader.
   block_fetch u_fetch (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .blk_req_i   (blk_req),
      .blk_num_i   (blk_num),
      .blk_ack_o   (blk_ack),
      .blk_err_o   (blk_err),
      .a_cyc_o     (a_cyc_o),
      .a_stb_o     (a_stb_o),
      .a_we_o      (a_we_o),
      .a_adr_o     (a_adr_o),
      .a_dat_i     (a_dat_i),
      .a_ack_i     (a_ack_i),
      .a_wat_i     (a_wat_i),
      .a_err_i     (a_err_i),
      .wr_valid_o  (wr_valid),
      .wr_data_o   (wr_data),
      .buf_space_i (buf_space)
   );

   // Buffer and port B writer.
   block_store u_store (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .run_i       (run),
      .wr_valid_i  (wr_valid),
      .wr_data_i   (wr_data),
      .buf_space_o (buf_space),
      .buf_empty_o (buf_empty),
      .b_cyc_o     (b_cyc_o),
      .b_stb_o     (b_stb_o),
      .b_we_o      (b_we_o),
      .b_adr_o     (b_adr_o),
      .b_dat_o     (b_dat_o),
      .b_ack_i     (b_ack_i),
      .b_wat_i     (b_wat_i)
   );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the prefetcher testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
   -f sim.f --top-module tb_prefetch

out="$(./obj_dir/Vtb_prefetch)"
printf '%s\n' "$out"

# Only the pass line marks success.
grep -qx "sim passed" <<< "$out"

// ==== sim.f ====
+incdir+design
design/wb_bus_pkg.sv
design/prefetch_pkg.sv
design/prefetch_ctrl.sv
design/block_fetch.sv
design/block_store.sv
design/wb_prefetch_top.sv
test/tb_clkgen.sv
test/prefetch_checker.sv
test/tb_prefetch.sv

// ==== test/prefetch_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module prefetch_checker import wb_bus_pkg::*; (
   input logic    clk_i,
   input logic    rst_i,
   input logic    start_req_i,
   input logic    start_ack_i,
   input logic    err_i,
   input logic    a_cyc_i,
   input logic    a_stb_i,
   input logic    a_we_i,
   input logic    a_err_i,
   input logic    b_cyc_i,
   input logic    b_stb_i,
   input logic    b_we_i,
   input wb_adr_t b_adr_i,
   input wb_dat_t b_dat_i,
   input logic    b_ack_i,
   input logic    b_wat_i
);

   // Failed assertions, summed up by the testbench.
   int   fail_cnt = 0;
   // Set by a port A error, cleared by the start acknowledge.
   logic err_hold;

   always_ff @(posedge clk_i) begin
      if (rst_i || start_ack_i) begin
         err_hold <= 1'b0;
      end else if (a_cyc_i && a_err_i) begin
         err_hold <= 1'b1;
      end
   end

   // --------------------------------------------------
   // Reset and bus discipline.
   // --------------------------------------------------
   a_reset_quiet: assert property (@(posedge clk_i) rst_i |=>
      !start_ack_i && !err_i && !a_cyc_i && !a_stb_i && !b_cyc_i && !b_stb_i)
      else begin $error("outputs active after reset"); fail_cnt++; end
   a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i) a_stb_i |-> a_cyc_i)
      else begin $error("port A strobe outside a cycle"); fail_cnt++; end
   a_read_only: assert property (@(posedge clk_i) disable iff (rst_i) a_cyc_i |-> !a_we_i)
      else begin $error("port A write enable high"); fail_cnt++; end
   a_b_write: assert property (@(posedge clk_i) disable iff (rst_i)
      b_stb_i |-> (b_cyc_i && b_we_i))
      else begin $error("port B strobe without cycle or write"); fail_cnt++; end

   // Word and address hold until the sink takes them.
   a_b_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      (b_stb_i && !(b_ack_i && !b_wat_i)) |=>
      (b_stb_i && $stable(b_adr_i) && $stable(b_dat_i)))
      else begin $error("port B word changed while pending"); fail_cnt++; end

   // --------------------------------------------------
   // Start handshake and error abort.
   // --------------------------------------------------
   a_ack_holds: assert property (@(posedge clk_i) disable iff (rst_i)
      (start_ack_i && start_req_i) |=> start_ack_i)
      else begin $error("start ack fell under a request"); fail_cnt++; end
   a_ack_falls: assert property (@(posedge clk_i) disable iff (rst_i)
      (start_ack_i && !start_req_i) |=> !start_ack_i)
      else begin $error("start ack stuck after request drop"); fail_cnt++; end
   a_ack_asked: assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(start_ack_i) |-> start_req_i)
      else begin $error("start ack without request"); fail_cnt++; end
   a_err_framed: assert property (@(posedge clk_i) disable iff (rst_i) err_i |-> start_ack_i)
      else begin $error("err outside start ack"); fail_cnt++; end
   a_no_read_after_err: assert property (@(posedge clk_i) disable iff (rst_i)
      err_hold |-> !a_cyc_i)
      else begin $error("port A read after error"); fail_cnt++; end

endmodule

`default_nettype wire

// ==== test/tb_clkgen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
   parameter int HALF_NS    = 20,
   parameter int RST_CYCLES = 10
) (
   output logic clk_o,
   output logic rst_o
);

   // Free-running clock, 40 ns period.
   initial begin
      clk_o = 1'b0;
      forever #HALF_NS clk_o = ~clk_o;
   end

   // Reset held for a fixed number of cycles.
   // Released just after an edge, like all stimulus.
   initial begin
      rst_o = 1'b1;
      repeat (RST_CYCLES) @(posedge clk_o);
      #1 rst_o = 1'b0;
   end

endmodule

`default_nettype wire

// ==== test/tb_prefetch.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "prefetch_consts.svh"

module tb_prefetch import wb_bus_pkg::*, prefetch_pkg::*; ();

   localparam int N_TESTS     = 6;
   localparam int TEST_CYCLES = 2000;

   logic      clk;
   logic      rst;
   logic      start_req = 1'b0;
   pf_count_t count     = '0;
   logic      start_ack;
   logic      err;
   logic      a_cyc;
   logic      a_stb;
   logic      a_we;
   wb_adr_t   a_adr;
   wb_dat_t   a_dat = '0;
   logic      a_ack = 1'b0;
   logic      a_wat = 1'b0;
   logic      a_err = 1'b0;
   logic      b_cyc;
   logic      b_stb;
   logic      b_we;
   wb_adr_t   b_adr;
   wb_dat_t   b_dat;
   logic      b_ack = 1'b0;
   logic      b_wat = 1'b0;

   // Slave behaviour and per-test expectations.
   int        seed       = 32'h23ddacea;
   bit        waits_on   = 1'b0;
   int        err_at     = -1;
   bit        err_exp    = 1'b0;
   int        exp_writes = 0;
   int        rd_cnt     = 0;
   int        wr_cnt     = 0;
   int        rd_base    = 0;
   int        wr_base    = 0;
   int        err_cnt    = 0;
   int        n_pass     = 0;
   wb_dat_t   sink_mem [1 << `PF_SBITS];

   // Source content, every address bit shows in the word.
   function automatic wb_dat_t src_word(input wb_adr_t adr);
      return 32'h5ab3_c000 ^ {adr[3:0], adr[9:4], 12'h0, adr};
   endfunction

   // Source address of sink write k.
   function automatic wb_adr_t src_adr_of(input int k);
      return wb_adr_t'((k / `PF_BSIZE) * `PF_BSTRIDE + (k % `PF_BSIZE));
   endfunction

   // Count rounded up to whole blocks, at least one block.
   function automatic int padded_count(input int cnt);
      int blocks;
      blocks = (cnt + `PF_BSIZE - 1) / `PF_BSIZE;
      return ((blocks == 0) ? 1 : blocks) * `PF_BSIZE;
   endfunction

   function automatic int total_errors();
      return err_cnt + wb_prefetch_top_inst.u_checker.fail_cnt;
   endfunction

   tb_clkgen u_clkgen (.clk_o(clk), .rst_o(rst));

   wb_prefetch_top wb_prefetch_top_inst (
      .clk_i(clk), .rst_i(rst), .start_req_i(start_req), .count_i(count),
      .start_ack_o(start_ack), .err_o(err),
      .a_cyc_o(a_cyc), .a_stb_o(a_stb), .a_we_o(a_we), .a_adr_o(a_adr),
      .a_dat_i(a_dat), .a_ack_i(a_ack), .a_wat_i(a_wat), .a_err_i(a_err),
      .b_cyc_o(b_cyc), .b_stb_o(b_stb), .b_we_o(b_we), .b_adr_o(b_adr),
      .b_dat_o(b_dat), .b_ack_i(b_ack), .b_wat_i(b_wat)
   );

   bind wb_prefetch_top prefetch_checker u_checker (
      .clk_i(clk_i), .rst_i(rst_i), .start_req_i(start_req_i), .start_ack_i(start_ack_o),
      .err_i(err_o), .a_cyc_i(a_cyc_o), .a_stb_i(a_stb_o), .a_we_i(a_we_o),
      .a_err_i(a_err_i), .b_cyc_i(b_cyc_o), .b_stb_i(b_stb_o), .b_we_i(b_we_o),
      .b_adr_i(b_adr_o), .b_dat_i(b_dat_o), .b_ack_i(b_ack_i), .b_wat_i(b_wat_i)
   );

   // --------------------------------------------------
   // Slave models, driven 1 ns after the edge.
   // --------------------------------------------------
   always @(posedge clk) begin
      #1;
      a_dat <= src_word(a_adr);
      a_wat <= waits_on && (($random(seed) & 3) == 0);
      a_ack <= !waits_on || (($random(seed) & 3) != 0);
      // Error fires once the chosen number of words was read.
      a_err <= a_cyc && (err_at >= 0) && (rd_cnt - rd_base == err_at);
      b_wat <= waits_on && (($random(seed) & 3) == 0);
      b_ack <= !waits_on || (($random(seed) & 1) != 0);
   end

   // Completed reads on port A, recorded writes on port B.
   always @(posedge clk) begin
      if (a_stb && a_ack && !a_err) begin
         rd_cnt <= rd_cnt + 1;
      end
      if (b_stb && b_ack && !b_wat) begin
         sink_mem[b_adr] <= b_dat;
         wr_cnt <= wr_cnt + 1;
      end
   end

   // --------------------------------------------------
   // Result checks.
   // --------------------------------------------------
   a_sink_data: assert property (@(posedge clk) disable iff (rst)
      (b_stb && b_ack && !b_wat) |-> (b_dat == src_word(src_adr_of(wr_cnt - wr_base))))
      else begin
         $display("ERR %0t: sink write %0d data %h", $time, wr_cnt - wr_base, b_dat);
         err_cnt++;
      end
   a_sink_adr: assert property (@(posedge clk) disable iff (rst)
      (b_stb && b_ack && !b_wat) |-> (b_adr == wb_adr_t'(wr_cnt - wr_base)))
      else begin
         $display("ERR %0t: sink address %0d, write %0d", $time, b_adr, wr_cnt - wr_base);
         err_cnt++;
      end
   // Word totals and error flag once the prefetch reports done.
   a_done_count: assert property (@(posedge clk) disable iff (rst)
      $rose(start_ack) |-> ((wr_cnt - wr_base == exp_writes) && (err == err_exp)
      && (wr_cnt - wr_base == rd_cnt - rd_base)))
      else begin
         $display("ERR %0t: %0d writes, %0d reads, expected %0d, err %0b", $time,
            wr_cnt - wr_base, rd_cnt - rd_base, exp_writes, err);
         err_cnt++;
      end

   // --------------------------------------------------
   // Stimulus.
   // --------------------------------------------------
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic run_prefetch(input int cnt, input bit waits, input int fail_at);
      int errs_before;
      int k;
      errs_before = total_errors();
      waits_on    = waits;
      err_at      = fail_at;
      err_exp     = (fail_at >= 0);
      exp_writes  = err_exp ? fail_at : padded_count(cnt);
      rd_base     = rd_cnt;
      wr_base     = wr_cnt;
      count       = pf_count_t'(cnt);
      start_req   = 1'b1;
      while (!start_ack) next_cycle();
      // Requester keeps asking for a few cycles after the acknowledge.
      repeat (3) next_cycle();
      start_req = 1'b0;
      while (start_ack) next_cycle();
      err_at = -1;
      // Sink memory holds the source words in write order.
      for (k = 0; k < exp_writes; k++) begin
         assert (sink_mem[k] == src_word(src_adr_of(k)))
            else begin
               $display("ERR %0t: sink word %0d holds %h", $time, k, sink_mem[k]);
               err_cnt++;
            end
      end
      if (total_errors() == errs_before) begin
         n_pass++;
      end
      $display("count %0d, waits %0b: %0d words written, %0s", cnt, waits,
         wr_cnt - wr_base, (total_errors() == errs_before) ? "ok" : "FAILED");
   endtask

   initial begin
      wait (!rst);
      next_cycle();
      run_prefetch(1, 1'b0, -1);
      run_prefetch(24, 1'b0, -1);
      run_prefetch(25, 1'b1, -1);
      run_prefetch(200, 1'b1, -1);
      // Error partway through the second block.
      run_prefetch(48, 1'b1, 30);
      run_prefetch(25, 1'b1, -1);
      $display("%0d tests, %0d passed, %0d errors", N_TESTS, n_pass, total_errors());
      if (total_errors() == 0 && n_pass == N_TESTS) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   // Watchdog over the whole run.
   initial begin
      repeat (N_TESTS * TEST_CYCLES) @(posedge clk);
      $display("Timeout: prefetch did not finish within %0d cycles", N_TESTS * TEST_CYCLES);
      $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire
